// File: Makefile
TOP       ?= tb_usb_dfu_router
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
BUILD     ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP VERILATOR FLAGS BUILD"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f all.f
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: all.f
src/usb_dfu_pkg.sv
src/rst_gate_gen.sv
src/endp_router.sv
src/ep_fifo.sv
src/dfu_status_sync.sv
src/app_steer.sv
src/usb_dfu_router.sv
bench/tb_usb_dfu_router.sv

// File: bench/tb_usb_dfu_router.sv
`timescale 1ns/1ps

module tb_usb_dfu_router;
    import usb_dfu_pkg::*;

    localparam int K_OUT = 0;
    localparam int K_IN = 1;
    localparam int K_UPLOAD = 2;
    localparam int K_STATUS = 3;
    localparam int NSTEPS = 14;
    localparam int DST_NONE = -1;
    localparam int DST_DFU = 2;
    localparam dfu_ctrl_t C_ACM = 5'b00000;
    localparam dfu_ctrl_t C_DN = 5'b10110;
    localparam dfu_ctrl_t C_UP = 5'b11010;
    localparam dfu_ctrl_t C_CLR = 5'b00001;

    typedef struct {
        int         kind;
        dfu_ctrl_t  ctrl;
        int         endp;
        int         cnt;
        int         dst;
        logic       nak;
        logic [3:0] status;
        logic [3:0] exp_status;
        logic       exp_clr;
        logic       bus_rst;
        logic       drain;
        logic       busy;
    } step_t;

    logic                 clk_i, rstn_i, clk_gate_o;
    sie_rx_t              rx_i;
    sie_tx_t              tx_o;
    dfu_ctrl_t            ctrl_i;
    dfu_report_t          report_o;
    byte_t [CHANNELS-1:0] out_data_o, in_data_i;
    logic [CHANNELS-1:0]  out_valid_o, out_ready_i, in_valid_i, in_ready_o;
    byte_t                dfu_out_data_o, dfu_in_data_i;
    logic                 dfu_out_valid_o, dfu_out_ready_i, dfu_in_valid_i, dfu_in_ready_o;
    logic                 dfu_out_en_o, dfu_in_en_o, dfu_busy_i, dfu_clear_status_o;
    logic [3:0]           dfu_status_i;

    step_t       steps [NSTEPS];
    logic [31:0] seed;
    byte_t       up_q[$];

    usb_dfu_router u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else abort_run($sformatf("MISMATCH at %0t ns: %s", $time, msg));
    endtask

    task automatic timed_out(input string what);
        abort_run($sformatf("timeout while waiting for %s", what));
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic sample();
        @(negedge clk_i);
    endtask

    // payload bytes are bits 23:16 of a plain LCG state.
    function automatic byte_t next_byte();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[23:16];
    endfunction

    function automatic logic out_valid_at(input int dst);
        if (dst == DST_DFU) begin
            return dfu_out_valid_o;
        end
        if (dst >= 0) begin
            return out_valid_o[dst];
        end
        return |out_valid_o | dfu_out_valid_o;
    endfunction

    function automatic byte_t out_data_at(input int dst);
        if (dst == DST_DFU) begin
            return dfu_out_data_o;
        end
        return out_data_o[dst];
    endfunction

    task automatic set_out_ready(input int dst, input logic v);
        if (dst == DST_DFU) begin
            dfu_out_ready_i = v;
        end else if (dst >= 0) begin
            out_ready_i[dst] = v;
        end
    endtask

    task automatic drive_in(input int dst, input logic v, input byte_t b);
        if (dst == DST_DFU) begin
            dfu_in_valid_i = v;
            dfu_in_data_i  = b;
        end else begin
            in_valid_i[dst] = v;
            in_data_i[dst]  = b;
        end
    endtask

    // one application IN byte; it is pushed on the following rising edge.
    task automatic load_in(input int dst, input byte_t b);
        next_cycle();
        drive_in(dst, 1'b1, b);
        sample();
        if (dst == DST_DFU) begin
            check(dfu_in_ready_o, "dfu_in_ready_o low while loading");
        end else begin
            check(in_ready_o[dst], "in_ready_o low while loading");
        end
    endtask

    task automatic pop_in(input byte_t exp);
        sample();
        check(tx_o.in_valid, "in_valid low with IN data pending");
        check(tx_o.in_data == exp, $sformatf("IN data expected %h got %h", exp, tx_o.in_data));
        next_cycle();
        rx_i.in_req = 1'b1;
        next_cycle();
        rx_i.in_req = 1'b0;
    endtask

    task automatic run_out(input step_t st);
        byte_t b;
        byte_t q[$];
        int    waited;
        for (int i = 0; i < st.cnt; i++) begin
            b = next_byte();
            if (st.dst != DST_NONE) begin
                q.push_back(b);
            end
            next_cycle();
            rx_i.out_valid = 1'b1;
            rx_i.out_data  = b;
            next_cycle();
            rx_i.out_valid = 1'b0;
            sample();
            check(out_valid_at(st.dst) == (st.dst != DST_NONE), "OUT valid after strobe");
        end
        check(tx_o.out_nak == st.nak, "out_nak level");
        if (st.dst == DST_DFU) begin
            check(out_valid_o == '0, "ACM out_valid_o high in DFU mode");
            check(dfu_out_en_o, "dfu_out_en_o low in download");
        end
        if (st.drain && st.dst != DST_NONE) begin
            next_cycle();
            set_out_ready(st.dst, 1'b1);
            waited = 0;
            while (q.size() != 0) begin
                sample();
                if (out_valid_at(st.dst)) begin
                    b = q.pop_front();
                    check(out_data_at(st.dst) == b,
                          $sformatf("OUT data expected %h got %h", b, out_data_at(st.dst)));
                    waited = 0;
                end else begin
                    waited++;
                    if (waited > BIT_SAMPLES) timed_out("OUT data at the application port");
                end
            end
            next_cycle();
            set_out_ready(st.dst, 1'b0);
            sample();
            check(!out_valid_at(st.dst), "OUT FIFO not empty after drain");
        end
    endtask

    task automatic run_in(input step_t st);
        byte_t b;
        byte_t q[$];
        int    ch;
        ch = (st.endp - 1) / 2;
        for (int i = 0; i < st.cnt; i++) begin
            b = next_byte();
            q.push_back(b);
            load_in(ch, b);
        end
        next_cycle();
        drive_in(ch, 1'b0, 8'h00);
        while (q.size() != 0) begin
            pop_in(q.pop_front());
        end
        sample();
        check(!tx_o.in_valid, "in_valid high with IN FIFO empty");
    endtask

    task automatic run_upload(input step_t st);
        byte_t b;
        int    waited;
        dfu_status_i = st.status;
        for (int i = 0; i < st.cnt; i++) begin
            b = next_byte();
            up_q.push_back(b);
            load_in(DST_DFU, b);
        end
        next_cycle();
        drive_in(DST_DFU, 1'b0, 8'h00);
        check(dfu_in_en_o && out_valid_o == '0 && in_ready_o == '0, "upload port enables");
        waited = 0;
        sample();
        while (tx_o.in_nak != st.nak || (st.status != 0 && report_o.status != st.status)) begin
            waited++;
            if (waited > BIT_SAMPLES + 1) timed_out("upload in_nak and status");
            sample();
        end
        check(tx_o.in_valid == !st.nak, "upload in_valid against hold-off");
        if (st.drain) begin
            while (up_q.size() != 0) begin
                pop_in(up_q.pop_front());
            end
            sample();
            check(!tx_o.in_valid, "upload in_valid high after drain");
            check(report_o.done, "done low after upload drained");
        end
    endtask

    task automatic run_status(input step_t st);
        int waited;
        dfu_status_i    = st.status;
        dfu_busy_i      = st.busy;
        rx_i.bus_reset  = st.bus_rst;
        if (ctrl_i.clear_req) begin
            next_cycle();
            ctrl_i.clear_req = 1'b0;
        end
        // the sampled values must settle within one strobe period plus a cycle.
        waited = 0;
        sample();
        while ((report_o.status != st.exp_status || report_o.busy != st.busy ||
                dfu_clear_status_o != st.exp_clr) && waited <= BIT_SAMPLES) begin
            waited++;
            sample();
        end
        check(report_o.status == st.exp_status, "reported status");
        check(report_o.busy == st.busy, "reported busy");
        check(dfu_clear_status_o == st.exp_clr, "clear-status level");
        next_cycle();
        rx_i.bus_reset = 1'b0;
    endtask

    initial begin
        int waited;
        rstn_i          = 1'b0;
        rx_i            = '0;
        ctrl_i          = '0;
        out_ready_i     = '0;
        in_data_i       = '0;
        in_valid_i      = '0;
        dfu_out_ready_i = 1'b0;
        dfu_in_data_i   = 8'h00;
        dfu_in_valid_i  = 1'b0;
        dfu_busy_i      = 1'b0;
        dfu_status_i    = 4'h0;
        seed            = 32'h766b;
        // kind, ctrl, endp, count, dst, nak, status, exp status, exp clear, bus reset, drain, busy
        steps[0]  = '{K_OUT, C_ACM, 1, 4, 0, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        steps[1]  = '{K_OUT, C_ACM, 3, 3, 1, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        steps[2]  = '{K_OUT, C_ACM, 5, 2, DST_NONE, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        steps[3]  = '{K_IN, C_ACM, 3, 5, 1, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        steps[4]  = '{K_OUT, C_ACM, 1, 8, 0, 1'b1, 4'h0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        steps[5]  = '{K_OUT, C_DN, 0, 5, DST_DFU, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        steps[6]  = '{K_UPLOAD, C_UP, 0, 7, DST_DFU, 1'b1, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0};
        steps[7]  = '{K_UPLOAD, C_UP, 0, 1, DST_DFU, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0};
        steps[8]  = '{K_UPLOAD, C_UP, 0, 0, DST_DFU, 1'b0, 4'h3, 4'h3, 1'b0, 1'b0, 1'b1, 1'b0};
        steps[9]  = '{K_UPLOAD, C_UP, 0, 3, DST_DFU, 1'b0, 4'h3, 4'h3, 1'b0, 1'b0, 1'b1, 1'b0};
        steps[10] = '{K_STATUS, C_ACM, 1, 0, 0, 1'b0, 4'hF, 4'h0, 1'b0, 1'b0, 1'b0, 1'b1};
        steps[11] = '{K_STATUS, C_ACM, 1, 0, 0, 1'b0, 4'h3, 4'h3, 1'b0, 1'b0, 1'b0, 1'b0};
        steps[12] = '{K_STATUS, C_CLR, 1, 0, 0, 1'b0, 4'h3, 4'h3, 1'b1, 1'b0, 1'b0, 1'b1};
        steps[13] = '{K_STATUS, C_ACM, 1, 0, 0, 1'b0, 4'h3, 4'h3, 1'b0, 1'b1, 1'b0, 1'b0};

        repeat (5) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        sample();
        check(out_valid_o == '0 && in_ready_o == '1, "ACM port state after reset");
        check(!dfu_out_valid_o && !dfu_in_ready_o, "DFU handshakes after reset");
        check(!dfu_out_en_o && !dfu_in_en_o, "DFU enables after reset");
        check(!tx_o.in_valid && !dfu_clear_status_o, "engine and status after reset");

        waited = 0;
        while (!clk_gate_o) begin
            waited++;
            if (waited > 4 * BIT_SAMPLES) timed_out("first clk_gate_o pulse");
            sample();
        end
        for (int k = 1; k <= BIT_SAMPLES; k++) begin
            sample();
            check(clk_gate_o == (k == BIT_SAMPLES), "clk_gate_o period");
        end

        for (int s = 0; s < NSTEPS; s++) begin
            next_cycle();
            ctrl_i    = steps[s].ctrl;
            rx_i.endp = 4'(steps[s].endp);
            case (steps[s].kind)
                K_OUT:    run_out(steps[s]);
                K_IN:     run_in(steps[s]);
                K_UPLOAD: run_upload(steps[s]);
                default:  run_status(steps[s]);
            endcase
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: src/app_steer.sv
`timescale 1ns/1ps

module app_steer (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    input  usb_dfu_pkg::dfu_ctrl_t                         ctrl_i,
    output usb_dfu_pkg::app_mode_e                         mode_o,
    input  logic                                           out_empty_i,
    output logic                                           flush_o,
    input  usb_dfu_pkg::byte_t [usb_dfu_pkg::CHANNELS-1:0] fifo_out_data_i,
    input  logic [usb_dfu_pkg::CHANNELS-1:0]               fifo_out_valid_i,
    output logic [usb_dfu_pkg::CHANNELS-1:0]               fifo_out_ready_o,
    output usb_dfu_pkg::byte_t [usb_dfu_pkg::CHANNELS-1:0] fifo_in_data_o,
    output logic [usb_dfu_pkg::CHANNELS-1:0]               fifo_in_valid_o,
    input  logic [usb_dfu_pkg::CHANNELS-1:0]               fifo_in_ready_i,
    output usb_dfu_pkg::byte_t [usb_dfu_pkg::CHANNELS-1:0] out_data_o,
    output logic [usb_dfu_pkg::CHANNELS-1:0]               out_valid_o,
    input  logic [usb_dfu_pkg::CHANNELS-1:0]               out_ready_i,
    input  usb_dfu_pkg::byte_t [usb_dfu_pkg::CHANNELS-1:0] in_data_i,
    input  logic [usb_dfu_pkg::CHANNELS-1:0]               in_valid_i,
    output logic [usb_dfu_pkg::CHANNELS-1:0]               in_ready_o,
    output usb_dfu_pkg::byte_t                             dfu_out_data_o,
    output logic                                           dfu_out_valid_o,
    input  logic                                           dfu_out_ready_i,
    input  usb_dfu_pkg::byte_t                             dfu_in_data_i,
    input  logic                                           dfu_in_valid_i,
    output logic                                           dfu_in_ready_o,
    output logic                                           dfu_out_en_o,
    output logic                                           dfu_in_en_o
);
    import usb_dfu_pkg::*;

    logic acm;
    logic dnload_act;
    logic upload_act;

    // upload wins if the control endpoint ever reports both transfers.
    always_comb begin
        if (!ctrl_i.mode) begin
            mode_o = ACM;
        end else if (ctrl_i.upload) begin
            mode_o = DFU_UPLOAD;
        end else if (ctrl_i.dnload) begin
            mode_o = DFU_DNLOAD;
        end else begin
            mode_o = DFU_IDLE;
        end
    end

    assign acm        = mode_o == ACM;
    assign dnload_act = mode_o == DFU_DNLOAD;
    assign upload_act = mode_o == DFU_UPLOAD;

    always_comb begin
        for (int j = 0; j < CHANNELS; j++) begin
            out_valid_o[j]      = acm & fifo_out_valid_i[j];
            in_ready_o[j]       = acm & fifo_in_ready_i[j];
            fifo_out_ready_o[j] = acm & out_ready_i[j];
            fifo_in_valid_o[j]  = acm & in_valid_i[j];
            fifo_in_data_o[j]   = in_data_i[j];
        end
        // outside ACM mode channel 0 belongs to the DFU port.
        if (!acm) begin
            fifo_out_ready_o[0] = dnload_act & dfu_out_ready_i;
            fifo_in_valid_o[0]  = upload_act & dfu_in_valid_i;
            fifo_in_data_o[0]   = dfu_in_data_i;
        end
    end

    assign out_data_o      = fifo_out_data_i;
    assign dfu_out_data_o  = fifo_out_data_i[0];
    assign dfu_out_valid_o = dnload_act & fifo_out_valid_i[0];
    assign dfu_in_ready_o  = upload_act & fifo_in_ready_i[0];
    assign dfu_out_en_o    = ctrl_i.dnload | ~out_empty_i;
    assign dfu_in_en_o     = ctrl_i.upload;

    // channel 0 is emptied while DFU sits idle with no download data left.
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            flush_o <= 1'b0;
        end else begin
            flush_o <= ctrl_i.mode & ~ctrl_i.upload & ~ctrl_i.clear_req &
                       ~ctrl_i.dnload & out_empty_i;
        end
    end

endmodule

// File: src/dfu_status_sync.sv
`timescale 1ns/1ps

module dfu_status_sync (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     clk_gate_i,
    input  logic                     bus_reset_i,
    input  logic                     clear_req_i,
    input  logic                     busy_i,
    input  logic [3:0]               status_i,
    input  logic                     in_empty_i,
    output logic                     status_set_o,
    output logic                     clear_status_o,
    output usb_dfu_pkg::dfu_report_t report_o
);
    import usb_dfu_pkg::*;

    logic busy_q;
    logic status_q;
    logic clear_pend_q;

    // a short clear request is held until the next bit strobe sees it.
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q         <= 1'b0;
            status_q       <= 1'b0;
            clear_pend_q   <= 1'b0;
            clear_status_o <= 1'b0;
        end else if (clk_gate_i) begin
            busy_q         <= busy_i;
            status_q       <= |status_i;
            clear_pend_q   <= clear_req_i;
            clear_status_o <= (clear_req_i | clear_pend_q | clear_status_o) &
                              status_q & ~bus_reset_i;
        end else if (clear_req_i) begin
            clear_pend_q <= 1'b1;
        end
    end

    assign status_set_o = status_q;

    always_comb begin
        report_o.status = 4'h0;
        if (status_q && status_i != DFU_STATUS_END) begin
            report_o.status = status_i;
        end
        report_o.busy = busy_q;
        // the operation is done once the last upload byte has left.
        report_o.done = status_q & in_empty_i;
    end

endmodule

// File: src/endp_router.sv
`timescale 1ns/1ps

module endp_router (
    input  usb_dfu_pkg::sie_rx_t                                 rx_i,
    input  logic                                                 fifo_sel_i,
    input  usb_dfu_pkg::app_mode_e                               mode_i,
    input  logic                                                 status_set_i,
    input  usb_dfu_pkg::fifo_flags_t [usb_dfu_pkg::CHANNELS-1:0] flags_i,
    input  usb_dfu_pkg::byte_t [usb_dfu_pkg::CHANNELS-1:0]       fifo_data_i,
    output logic [usb_dfu_pkg::CHANNELS-1:0]                     wr_o,
    output logic [usb_dfu_pkg::CHANNELS-1:0]                     pop_o,
    output usb_dfu_pkg::sie_tx_t                                 tx_o
);
    import usb_dfu_pkg::*;

    logic [CHANNELS-1:0] sel;
    logic                dfu_fifo;
    logic                upload_hold;
    logic                in_release;

    assign dfu_fifo    = (rx_i.endp == ENDP_CTRL) && fifo_sel_i;
    assign upload_hold = dfu_fifo && (mode_i == DFU_UPLOAD);
    // an upload packet goes out once it is full or the transfer has ended.
    assign in_release  = flags_i[0].in_full | status_set_i;

    // bulk endpoint 2j+1 belongs to channel j, but only outside DFU mode.
    always_comb begin
        sel = '0;
        for (int j = 0; j < CHANNELS; j++) begin
            if (int'(rx_i.endp) == 2 * j + 1 && mode_i == ACM) begin
                sel[j] = 1'b1;
            end
        end
        if (dfu_fifo) begin
            sel[0] = 1'b1;
        end
    end

    assign wr_o  = sel & {CHANNELS{rx_i.out_valid}};
    assign pop_o = sel & {CHANNELS{rx_i.in_req}};

    always_comb begin
        tx_o.in_data  = fifo_data_i[0];
        tx_o.in_valid = 1'b0;
        tx_o.in_nak   = 1'b0;
        tx_o.out_nak  = 1'b0;
        for (int j = 0; j < CHANNELS; j++) begin
            if (sel[j]) begin
                tx_o.in_data  = fifo_data_i[j];
                tx_o.in_valid = ~flags_i[j].in_empty;
                tx_o.out_nak  = flags_i[j].out_nak;
            end
        end
        if (upload_hold) begin
            tx_o.in_valid = ~flags_i[0].in_empty & in_release;
            tx_o.in_nak   = ~in_release;
        end
    end

endmodule

// File: src/ep_fifo.sv
`timescale 1ns/1ps

module ep_fifo (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     flush_i,
    input  logic                     wr_i,
    input  usb_dfu_pkg::byte_t       wr_data_i,
    output logic                     out_valid_o,
    output usb_dfu_pkg::byte_t       out_data_o,
    input  logic                     out_ready_i,
    input  logic                     in_valid_i,
    input  usb_dfu_pkg::byte_t       in_data_i,
    output logic                     in_ready_o,
    input  logic                     pop_i,
    output usb_dfu_pkg::byte_t       head_o,
    output usb_dfu_pkg::fifo_flags_t flags_o
);
    import usb_dfu_pkg::*;

    byte_t                         out_mem [FIFO_DEPTH];
    byte_t                         in_mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] out_wr_q, out_rd_q;
    logic [$clog2(FIFO_DEPTH)-1:0] in_wr_q, in_rd_q;
    logic [$clog2(FIFO_DEPTH):0]   out_cnt_q, in_cnt_q;
    logic                          out_full, in_full;
    logic                          out_push, out_pop, in_push, in_pop;

    assign out_full = int'(out_cnt_q) == FIFO_DEPTH;
    assign in_full  = int'(in_cnt_q) == FIFO_DEPTH;

    // the engine is told to NAK when full, so a write then is dropped.
    assign out_push = wr_i & ~out_full;
    assign out_pop  = out_valid_o & out_ready_i;
    assign in_push  = in_valid_i & in_ready_o;
    assign in_pop   = pop_i & (in_cnt_q != '0);

    always_ff @(posedge clk_i) begin
        if (out_push) begin
            out_mem[out_wr_q] <= wr_data_i;
        end
        if (in_push) begin
            in_mem[in_wr_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_wr_q  <= '0;
            out_rd_q  <= '0;
            out_cnt_q <= '0;
            in_wr_q   <= '0;
            in_rd_q   <= '0;
            in_cnt_q  <= '0;
        end else if (flush_i) begin
            out_wr_q  <= '0;
            out_rd_q  <= '0;
            out_cnt_q <= '0;
            in_wr_q   <= '0;
            in_rd_q   <= '0;
            in_cnt_q  <= '0;
        end else begin
            out_wr_q  <= out_wr_q + out_push;
            out_rd_q  <= out_rd_q + out_pop;
            out_cnt_q <= out_cnt_q + out_push - out_pop;
            in_wr_q   <= in_wr_q + in_push;
            in_rd_q   <= in_rd_q + in_pop;
            in_cnt_q  <= in_cnt_q + in_push - in_pop;
        end
    end

    assign out_valid_o = out_cnt_q != '0;
    assign out_data_o  = out_mem[out_rd_q];
    assign in_ready_o  = ~in_full;
    assign head_o      = in_mem[in_rd_q];

    assign flags_o.out_empty = out_cnt_q == '0;
    assign flags_o.in_empty  = in_cnt_q == '0;
    assign flags_o.in_full   = in_full;
    assign flags_o.out_nak   = out_full;

endmodule

// File: src/rst_gate_gen.sv
`timescale 1ns/1ps

module rst_gate_gen (
    input  logic clk_i,
    input  logic rstn_i,
    output logic rstn_o,
    output logic clk_gate_o
);
    import usb_dfu_pkg::*;

    logic [1:0]                     rstn_sq;
    logic [$clog2(BIT_SAMPLES)-1:0] cnt_q;

    // the reset asserts at once and is released two edges after rstn_i rises.
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rstn_sq <= 2'b00;
        end else begin
            rstn_sq <= {1'b1, rstn_sq[1]};
        end
    end

    assign rstn_o = rstn_sq[0];

    // the strobe is registered on the counter wrap, one pulse per USB bit.
    always_ff @(posedge clk_i or negedge rstn_o) begin
        if (!rstn_o) begin
            cnt_q      <= '0;
            clk_gate_o <= 1'b0;
        end else if (int'(cnt_q) == BIT_SAMPLES - 1) begin
            cnt_q      <= '0;
            clk_gate_o <= 1'b1;
        end else begin
            cnt_q      <= cnt_q + 1'b1;
            clk_gate_o <= 1'b0;
        end
    end

endmodule

// File: src/usb_dfu_pkg.sv
package usb_dfu_pkg;

    // number of ACM channels; channel 0 is shared with the DFU function.
    localparam int CHANNELS = 2;
    // clk_i cycles per full-speed USB bit.
    localparam int BIT_SAMPLES = 4;
    // bytes per FIFO direction, one max-size packet.
    localparam int FIFO_DEPTH = 8;

    typedef logic [7:0] byte_t;
    typedef logic [3:0] endp_t;

    localparam endp_t ENDP_CTRL = 4'd0;
    // end of operation, reported to the host as OK.
    localparam logic [3:0] DFU_STATUS_END = 4'hF;

    typedef struct packed {
        endp_t endp;
        byte_t out_data;
        logic  out_valid;
        logic  in_req;
        logic  bus_reset;
    } sie_rx_t;

    typedef struct packed {
        byte_t in_data;
        logic  in_valid;
        logic  in_nak;
        logic  out_nak;
    } sie_tx_t;

    typedef struct packed {
        logic mode;
        logic upload;
        logic dnload;
        logic fifo_sel;
        logic clear_req;
    } dfu_ctrl_t;

    typedef struct packed {
        logic [3:0] status;
        logic       busy;
        logic       done;
    } dfu_report_t;

    typedef struct packed {
        logic out_empty;
        logic in_empty;
        logic in_full;
        logic out_nak;
    } fifo_flags_t;

    typedef enum logic [1:0] {
        ACM,
        DFU_IDLE,
        DFU_DNLOAD,
        DFU_UPLOAD
    } app_mode_e;

endpackage

// File: src/usb_dfu_router.sv
`timescale 1ns/1ps

module usb_dfu_router (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    input  usb_dfu_pkg::sie_rx_t                           rx_i,
    output usb_dfu_pkg::sie_tx_t                           tx_o,
    output logic                                           clk_gate_o,
    input  usb_dfu_pkg::dfu_ctrl_t                         ctrl_i,
    output usb_dfu_pkg::dfu_report_t                       report_o,
    output usb_dfu_pkg::byte_t [usb_dfu_pkg::CHANNELS-1:0] out_data_o,
    output logic [usb_dfu_pkg::CHANNELS-1:0]               out_valid_o,
    input  logic [usb_dfu_pkg::CHANNELS-1:0]               out_ready_i,
    input  usb_dfu_pkg::byte_t [usb_dfu_pkg::CHANNELS-1:0] in_data_i,
    input  logic [usb_dfu_pkg::CHANNELS-1:0]               in_valid_i,
    output logic [usb_dfu_pkg::CHANNELS-1:0]               in_ready_o,
    output usb_dfu_pkg::byte_t                             dfu_out_data_o,
    output logic                                           dfu_out_valid_o,
    input  logic                                           dfu_out_ready_i,
    input  usb_dfu_pkg::byte_t                             dfu_in_data_i,
    input  logic                                           dfu_in_valid_i,
    output logic                                           dfu_in_ready_o,
    output logic                                           dfu_out_en_o,
    output logic                                           dfu_in_en_o,
    input  logic                                           dfu_busy_i,
    input  logic [3:0]                                     dfu_status_i,
    output logic                                           dfu_clear_status_o
);
    import usb_dfu_pkg::*;

    logic                         rstn;
    logic                         flush;
    logic                         status_set;
    app_mode_e                    mode;
    logic [CHANNELS-1:0]          wr, pop;
    fifo_flags_t [CHANNELS-1:0]   flags;
    byte_t [CHANNELS-1:0]         head;
    byte_t [CHANNELS-1:0]         fifo_out_data, fifo_in_data;
    logic [CHANNELS-1:0]          fifo_out_valid, fifo_out_ready;
    logic [CHANNELS-1:0]          fifo_in_valid, fifo_in_ready;

    rst_gate_gen u_rst_gate_gen (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .rstn_o     (rstn),
        .clk_gate_o (clk_gate_o)
    );

    endp_router u_endp_router (
        .rx_i         (rx_i),
        .fifo_sel_i   (ctrl_i.fifo_sel),
        .mode_i       (mode),
        .status_set_i (status_set),
        .flags_i      (flags),
        .fifo_data_i  (head),
        .wr_o         (wr),
        .pop_o        (pop),
        .tx_o         (tx_o)
    );

    for (genvar j = 0; j < CHANNELS; j++) begin : gen_chan
        ep_fifo u_ep_fifo (
            .clk_i       (clk_i),
            .rstn_i      (rstn),
            .flush_i     (flush && (j == 0)),
            .wr_i        (wr[j]),
            .wr_data_i   (rx_i.out_data),
            .out_valid_o (fifo_out_valid[j]),
            .out_data_o  (fifo_out_data[j]),
            .out_ready_i (fifo_out_ready[j]),
            .in_valid_i  (fifo_in_valid[j]),
            .in_data_i   (fifo_in_data[j]),
            .in_ready_o  (fifo_in_ready[j]),
            .pop_i       (pop[j]),
            .head_o      (head[j]),
            .flags_o     (flags[j])
        );
    end

    dfu_status_sync u_dfu_status_sync (
        .clk_i          (clk_i),
        .rstn_i         (rstn),
        .clk_gate_i     (clk_gate_o),
        .bus_reset_i    (rx_i.bus_reset),
        .clear_req_i    (ctrl_i.clear_req),
        .busy_i         (dfu_busy_i),
        .status_i       (dfu_status_i),
        .in_empty_i     (flags[0].in_empty),
        .status_set_o   (status_set),
        .clear_status_o (dfu_clear_status_o),
        .report_o       (report_o)
    );

    app_steer u_app_steer (
        .clk_i            (clk_i),
        .rstn_i           (rstn),
        .ctrl_i           (ctrl_i),
        .mode_o           (mode),
        .out_empty_i      (flags[0].out_empty),
        .flush_o          (flush),
        .fifo_out_data_i  (fifo_out_data),
        .fifo_out_valid_i (fifo_out_valid),
        .fifo_out_ready_o (fifo_out_ready),
        .fifo_in_data_o   (fifo_in_data),
        .fifo_in_valid_o  (fifo_in_valid),
        .fifo_in_ready_i  (fifo_in_ready),
        .out_data_o       (out_data_o),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .in_data_i        (in_data_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .dfu_out_data_o   (dfu_out_data_o),
        .dfu_out_valid_o  (dfu_out_valid_o),
        .dfu_out_ready_i  (dfu_out_ready_i),
        .dfu_in_data_i    (dfu_in_data_i),
        .dfu_in_valid_i   (dfu_in_valid_i),
        .dfu_in_ready_o   (dfu_in_ready_o),
        .dfu_out_en_o     (dfu_out_en_o),
        .dfu_in_en_o      (dfu_in_en_o)
    );

endmodule
